/* list.f */
src/preheat_pkg.sv
src/preheat_fsm.sv
src/pop_count_bank.sv
src/ifmap_fifo.sv
src/preheat_top.sv
tb/preheat_props.sv
tb/tb_top.sv

/* Makefile */
# Verilator build and run of the preheat testbench.
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/tb_top.sv */
//====================
// preheat testbench
// Fills the ifmap fifos, runs preheats of each layer type and checks the pe row words.
//====================
`timescale 1ns/10ps

module tb_top;

    import preheat_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int DONE_TIMEOUT = 100;   // cycles allowed from start to done.
    localparam int NUM_TESTS    = 6;
    localparam int TEST_BUDGET  = 300;   // upper bound on one test with its fills.
    localparam int WATCHDOG_CYC = RESET_CYCLES + NUM_TESTS * TEST_BUDGET + 50;

    logic                      clk;
    logic                      rst_n;
    logic                      start;
    layer_type_t               layer_type;
    logic [NUM_IFMAP_FIFO-1:0] push;
    ifmap_data_t               push_data [NUM_IFMAP_FIFO];
    logic [NUM_IFMAP_FIFO-1:0] full;
    logic [NUM_IFMAP_FIFO-1:0] pe_valid;
    ifmap_data_t               pe_data [NUM_IFMAP_FIFO];
    logic                      done;

    ifmap_data_t sb_q [NUM_IFMAP_FIFO][$];   // pushed words not yet seen on the pe row.
    int          got_cnt [NUM_IFMAP_FIFO];
    int          done_cnt;
    int          cyc = 0;
    int          start_cyc;
    int          err_cnt;
    int          test_err_base;
    int          tests_run;
    int          tests_failed;
    string       cur_test;
    logic [31:0] lfsr_q;
    ifmap_data_t mon_exp;

    preheat_top dut_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .start_preheat_i (start),
        .layer_type_i    (layer_type),
        .push_i          (push),
        .push_data_i     (push_data),
        .full_o          (full),
        .pe_valid_o      (pe_valid),
        .pe_data_o       (pe_data),
        .preheat_done_o  (done)
    );

    bind preheat_top preheat_props u_props (
        .clk     (clk),
        .rst_n   (rst_n),
        .state_i (u_fsm.state_q),
        .load_i  (load),
        .push_i  (push_i),
        .pop_i   (pop),
        .done_i  (preheat_done_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // fibonacci lfsr with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_word(output ifmap_data_t w);
        w = '0;
        for (int i = 0; i < IFMAP_DATA_W; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w      = {w[IFMAP_DATA_W-2:0], lfsr_q[0]};
        end
    endtask

    // a row pops once for pointwise, 3*(g+1) times in a complete depthwise group and never
    // otherwise.
    function automatic int expected_pops(input int row, input layer_type_t lt);
        int group;
        int pops;
        group = row / 3;
        pops  = 0;
        if (lt == LAYER_PW) begin
            pops = 1;
        end else if (lt == LAYER_DW && (group + 1) * 3 <= NUM_IFMAP_FIFO) begin
            pops = 3 * (group + 1);
        end
        return pops;
    endfunction

    function automatic int total_errors();
        return err_cnt + dut_i.u_props.fail_cnt;
    endfunction

    // words leave the scoreboard in the order they reach the pe rows.
    always @(negedge clk) begin
        if (rst_n) begin
            for (int k = 0; k < NUM_IFMAP_FIFO; k++) begin
                if (pe_valid[k]) begin
                    got_cnt[k]++;
                    if (sb_q[k].size() == 0) begin
                        $display("error: test %s, row %0d delivered a word never pushed",
                                 cur_test, k);
                        err_cnt++;
                    end else begin
                        mon_exp = sb_q[k].pop_front();
                        assert (pe_data[k] == mon_exp) else begin
                            $display("mismatch test %s row %0d data: expected %h actual %h",
                                     cur_test, k, mon_exp, pe_data[k]);
                            err_cnt++;
                        end
                    end
                end
            end
            if (done) done_cnt++;
        end
    end

    task automatic fill_rows(input logic [NUM_IFMAP_FIFO-1:0] mask, input int target);
        bit          more;
        bit          exp_full;
        ifmap_data_t w;
        more = 1'b1;
        while (more) begin
            @(negedge clk);
            more = 1'b0;
            for (int k = 0; k < NUM_IFMAP_FIFO; k++) begin
                push[k]  = 1'b0;
                exp_full = (sb_q[k].size() == FIFO_DEPTH);
                assert (full[k] == exp_full) else begin
                    $display("mismatch test %s row %0d full: expected %0b actual %0b",
                             cur_test, k, exp_full, full[k]);
                    err_cnt++;
                end
                if (mask[k] && sb_q[k].size() < target && target <= FIFO_DEPTH) begin
                    rand_word(w);
                    push[k]      = 1'b1;
                    push_data[k] = w;
                    sb_q[k].push_back(w);
                    more         = 1'b1;
                end
            end
        end
    endtask

    task automatic feed_slowly(input int row, input int words, input int gap);
        ifmap_data_t w;
        for (int i = 0; i < words; i++) begin
            repeat (gap) @(negedge clk);
            rand_word(w);
            push[row]      = 1'b1;
            push_data[row] = w;
            sb_q[row].push_back(w);
            @(negedge clk);
            push[row] = 1'b0;
        end
    endtask

    task automatic start_preheat(input layer_type_t lt, input bit extra_strobe);
        @(negedge clk);
        for (int k = 0; k < NUM_IFMAP_FIFO; k++) got_cnt[k] = 0;
        done_cnt   = 0;
        start      = 1'b1;
        layer_type = lt;
        start_cyc  = cyc;
        @(negedge clk);
        if (extra_strobe) begin
            layer_type = LAYER_DW;   // a reload here would raise the pop counts.
            @(negedge clk);
        end
        start = 1'b0;
    endtask

    task automatic wait_done(input layer_type_t lt, input int exp_latency);
        int waited;
        waited = 0;
        while (!done && waited < DONE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("error: test %s, preheat done did not arrive within %0d cycles",
                     cur_test, DONE_TIMEOUT);
            err_cnt++;
        end else if (exp_latency > 0) begin
            assert (cyc - start_cyc == exp_latency) else begin
                $display("mismatch test %s done latency: expected %0d actual %0d",
                         cur_test, exp_latency, cyc - start_cyc);
                err_cnt++;
            end
        end
        @(posedge clk);
        @(posedge clk);   // one more monitor sample catches a stretched done.
        for (int k = 0; k < NUM_IFMAP_FIFO; k++) begin
            assert (got_cnt[k] == expected_pops(k, lt)) else begin
                $display("mismatch test %s row %0d words: expected %0d actual %0d",
                         cur_test, k, expected_pops(k, lt), got_cnt[k]);
                err_cnt++;
            end
        end
        assert (done_cnt == 1) else begin
            $display("mismatch test %s done pulses: expected 1 actual %0d", cur_test, done_cnt);
            err_cnt++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        test_err_base = total_errors();
    endtask

    task automatic end_test();
        tests_run++;
        if (total_errors() == test_err_base) begin
            $display("test %-16s pass", cur_test);
        end else begin
            tests_failed++;
            $display("test %-16s fail, %0d errors", cur_test, total_errors() - test_err_base);
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        start        = 1'b0;
        layer_type   = LAYER_PW;
        push         = '0;
        lfsr_q       = 32'hcd7f_9c4e;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        done_cnt     = 0;
        cur_test     = "reset";
        for (int k = 0; k < NUM_IFMAP_FIFO; k++) begin
            push_data[k] = '0;
            got_cnt[k]   = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // row 4 starts empty and trickles in while the other rows drain.
        begin_test("depthwise_stall");
        fill_rows(8'hef, 6);
        start_preheat(LAYER_DW, 1'b0);
        fork
            feed_slowly(4, 6, 3);
            wait_done(LAYER_DW, 0);
        join
        end_test();

        begin_test("pointwise");
        fill_rows(8'hff, 2);
        start_preheat(LAYER_PW, 1'b0);
        wait_done(LAYER_PW, 0);
        end_test();

        begin_test("back_to_back");
        fill_rows(8'hff, 2);
        start_preheat(LAYER_PW, 1'b1);
        wait_done(LAYER_PW, 0);
        start_preheat(LAYER_PW, 1'b0);
        wait_done(LAYER_PW, 0);
        end_test();

        begin_test("layer_code_2");
        fill_rows(8'hff, 1);
        start_preheat(2'd2, 1'b0);
        wait_done(2'd2, 2);
        end_test();

        begin_test("layer_code_3");
        start_preheat(2'd3, 1'b0);
        wait_done(2'd3, 2);
        end_test();

        begin_test("depthwise_full");
        fill_rows(8'hff, 8);
        start_preheat(LAYER_DW, 1'b0);
        wait_done(LAYER_DW, 0);
        // rows 6 and 7 keep their words, so topping them up reaches the full flag.
        fill_rows(8'hc0, FIFO_DEPTH);
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYC);
        $display("error: watchdog expired after %0d cycles, the tests did not finish",
                 WATCHDOG_CYC);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* tb/preheat_props.sv */
//====================
// preheat assertions
// Controller rules checked on the preheat top, attached with bind.
//====================
`timescale 1ns/10ps

module preheat_props (
    input logic                                   clk,
    input logic                                   rst_n,
    input preheat_pkg::preheat_state_e            state_i,
    input logic                                   load_i,
    input logic [preheat_pkg::NUM_IFMAP_FIFO-1:0] push_i,
    input logic [preheat_pkg::NUM_IFMAP_FIFO-1:0] pop_i,
    input logic                                   done_i
);

    import preheat_pkg::*;

    int                        fail_cnt = 0;   // number of assertion failures so far.
    logic [FIFO_CNT_W-1:0]     level_q [NUM_IFMAP_FIFO];
    logic [NUM_IFMAP_FIFO-1:0] level_zero;

    // words held by each fifo, counted from its push and pop strobes alone.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < NUM_IFMAP_FIFO; k++) begin
                level_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < NUM_IFMAP_FIFO; k++) begin
                level_q[k] <= level_q[k] + FIFO_CNT_W'(push_i[k]) - FIFO_CNT_W'(pop_i[k]);
            end
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_IFMAP_FIFO; k++) begin
            level_zero[k] = (level_q[k] == '0);
        end
    end

    a_pop_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        (|pop_i) |-> (state_i == WAIT_DONE))
        else begin
            $error("fifo pop issued while the controller is not in the wait state");
            fail_cnt++;
        end

    a_pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        (pop_i & level_zero) == '0)
        else begin
            $error("fifo pop issued to an empty fifo");
            fail_cnt++;
        end

    a_done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |=> !done_i)
        else begin
            $error("preheat done stayed high for more than one cycle");
            fail_cnt++;
        end

    // a load leaves idle and lands in the wait state on the next edge.
    a_load_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        load_i |=> (state_i == WAIT_DONE && $past(state_i) == IDLE))
        else begin
            $error("pop counters loaded outside idle or without entering the wait state");
            fail_cnt++;
        end

endmodule

/* src/preheat_top.sv */
//====================
// preheat top
// Ifmap fifo bank with the controller that pushes first operands into the pe rows.
//====================
`timescale 1ns/10ps

module preheat_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start_preheat_i,
    input  preheat_pkg::layer_type_t               layer_type_i,
    input  logic [preheat_pkg::NUM_IFMAP_FIFO-1:0] push_i,
    input  preheat_pkg::ifmap_data_t               push_data_i [preheat_pkg::NUM_IFMAP_FIFO],
    output logic [preheat_pkg::NUM_IFMAP_FIFO-1:0] full_o,
    output logic [preheat_pkg::NUM_IFMAP_FIFO-1:0] pe_valid_o,
    output preheat_pkg::ifmap_data_t               pe_data_o [preheat_pkg::NUM_IFMAP_FIFO],
    output logic                                   preheat_done_o
);

    import preheat_pkg::*;

    logic                      load;
    logic                      need_pop;
    logic                      all_done;
    logic [NUM_IFMAP_FIFO-1:0] pop;
    logic [NUM_IFMAP_FIFO-1:0] fifo_empty;

    preheat_fsm u_fsm (
        .clk             (clk),
        .rst_n           (rst_n),
        .start_preheat_i (start_preheat_i),
        .all_done_i      (all_done),
        .load_o          (load),
        .need_pop_o      (need_pop),
        .preheat_done_o  (preheat_done_o)
    );

    // the counters latch the layer type on the same edge the fsm leaves idle.
    pop_count_bank u_cnt_bank (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_i       (load),
        .layer_type_i (layer_type_i),
        .need_pop_i   (need_pop),
        .fifo_empty_i (fifo_empty),
        .pop_o        (pop),
        .all_done_o   (all_done)
    );

    for (genvar k = 0; k < NUM_IFMAP_FIFO; k++) begin : g_fifo
        ifmap_fifo u_fifo (
            .clk         (clk),
            .rst_n       (rst_n),
            .push_i      (push_i[k]),
            .push_data_i (push_data_i[k]),
            .pop_i       (pop[k]),
            .empty_o     (fifo_empty[k]),
            .full_o      (full_o[k]),
            .pe_valid_o  (pe_valid_o[k]),
            .pe_data_o   (pe_data_o[k])
        );
    end

endmodule

/* src/ifmap_fifo.sv */
//====================
// ifmap fifo
// Circular buffer filled from l2 and drained into one pe row through a register.
//====================
`timescale 1ns/10ps

module ifmap_fifo (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     push_i,
    input  preheat_pkg::ifmap_data_t push_data_i,
    input  logic                     pop_i,
    output logic                     empty_o,
    output logic                     full_o,
    output logic                     pe_valid_o,
    output preheat_pkg::ifmap_data_t pe_data_o
);

    import preheat_pkg::*;

    ifmap_data_t           mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [FIFO_CNT_W-1:0] fill_q;
    logic                  push_ok;
    logic                  pop_ok;

    assign empty_o = (fill_q == '0);
    assign full_o  = (fill_q == FIFO_CNT_W'(FIFO_DEPTH));

    assign push_ok = push_i && !full_o;   // pushes into a full fifo are lost.
    assign pop_ok  = pop_i && !empty_o;

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
        end else begin
            // the depth is a power of two, so the pointers wrap by themselves.
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   fill_q <= fill_q + 1'b1;
                2'b01:   fill_q <= fill_q - 1'b1;
                default: fill_q <= fill_q;   // both or neither leave the level alone.
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pe_valid_o <= 1'b0;
        end else begin
            pe_valid_o <= pop_ok;
        end
    end

    // the word under the read pointer goes to the pe row one cycle after the pop.
    always_ff @(posedge clk) begin
        if (pop_ok) begin
            pe_data_o <= mem[rd_ptr_q];
        end
    end

endmodule

/* src/pop_count_bank.sv */
//====================
// pop count bank
// Per-fifo down-counters of remaining preheat pops, with the pop strobes.
//====================
`timescale 1ns/10ps

module pop_count_bank (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   load_i,
    input  preheat_pkg::layer_type_t               layer_type_i,
    input  logic                                   need_pop_i,
    input  logic [preheat_pkg::NUM_IFMAP_FIFO-1:0] fifo_empty_i,
    output logic [preheat_pkg::NUM_IFMAP_FIFO-1:0] pop_o,
    output logic                                   all_done_o
);

    import preheat_pkg::*;

    pop_cnt_t                  cnt_q [NUM_IFMAP_FIFO];
    logic [NUM_IFMAP_FIFO-1:0] cnt_zero;

    // initial pop count for one fifo under the given layer type.
    function automatic pop_cnt_t init_count(input int unsigned idx, input layer_type_t lt);
        int unsigned grp;
        int unsigned full_rows;
        grp       = idx / DW_GROUP_SIZE;
        full_rows = (NUM_IFMAP_FIFO / DW_GROUP_SIZE) * DW_GROUP_SIZE;
        if (lt == LAYER_PW) begin
            return pop_cnt_t'(1);
        end else if (lt == LAYER_DW && idx < full_rows) begin
            // group g pops three words per group index, counted from one.
            return pop_cnt_t'(DW_GROUP_SIZE * (grp + 1));
        end
        return pop_cnt_t'(0); // unknown codes and leftover rows.
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < NUM_IFMAP_FIFO; k++) begin
                cnt_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < NUM_IFMAP_FIFO; k++) begin
                if (load_i) begin
                    cnt_q[k] <= init_count(k, layer_type_i);
                end else if (pop_o[k]) begin
                    cnt_q[k] <= cnt_q[k] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_IFMAP_FIFO; k++) begin
            cnt_zero[k] = (cnt_q[k] == '0);
            // an empty fifo holds back only its own counter.
            pop_o[k]    = need_pop_i && !cnt_zero[k] && !fifo_empty_i[k];
        end
    end

    assign all_done_o = &cnt_zero;

endmodule

/* src/preheat_fsm.sv */
//====================
// preheat fsm
// Sequences a preheat from the start strobe to the one-cycle done pulse.
//====================
`timescale 1ns/10ps

module preheat_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic start_preheat_i,
    input  logic all_done_i,
    output logic load_o,
    output logic need_pop_o,
    output logic preheat_done_o
);

    import preheat_pkg::*;

    preheat_state_e state_q;
    preheat_state_e state_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_preheat_i) begin
                    state_d = WAIT_DONE;
                end
            end
            WAIT_DONE: begin
                // counts are loaded on the entry edge, so a zero layer leaves at once.
                if (all_done_i) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = IDLE;   // done is a single-cycle state.
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // a start seen outside idle is simply ignored.
    assign load_o = (state_q == IDLE) && start_preheat_i;

    assign need_pop_o     = (state_q == WAIT_DONE);
    assign preheat_done_o = (state_q == DONE);

endmodule

/* src/preheat_pkg.sv */
//====================
// preheat package
// Shared sizes, word types, layer codes and FSM states for the ifmap preheat stage.
//====================
package preheat_pkg;

    localparam int NUM_IFMAP_FIFO = 8;   // one fifo per pe row.
    localparam int FIFO_DEPTH     = 16;
    localparam int FIFO_PTR_W     = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W     = FIFO_PTR_W + 1; // needs to hold the full value.
    localparam int IFMAP_DATA_W   = 16;
    localparam int POP_CNT_W      = 5;
    localparam int LAYER_TYPE_W   = 2;

    // depthwise rows are handled in groups of this many fifos.
    localparam int DW_GROUP_SIZE  = 3;

    typedef logic [IFMAP_DATA_W-1:0] ifmap_data_t;
    typedef logic [POP_CNT_W-1:0]    pop_cnt_t;
    typedef logic [LAYER_TYPE_W-1:0] layer_type_t;

    localparam layer_type_t LAYER_PW = 2'd0; // pointwise.
    localparam layer_type_t LAYER_DW = 2'd1; // depthwise.

    typedef enum logic [1:0] {
        IDLE,
        WAIT_DONE,
        DONE
    } preheat_state_e;

endpackage
